// ==== design/traffic_settings.svh ====
`ifndef TRAFFIC_SETTINGS_SVH
`define TRAFFIC_SETTINGS_SVH

// controller word address and data widths
`define MEM_ADDR_W 24
`define MEM_DATA_W 128

// one RGB565 sample from the ray tracer
`define PIXEL_W 16

// accumulation buffer lives above the display buffer
`define RTX_BASE 24'h20_0000

// 1280x720 pixels, eight 16-bit pixels per controller word
`define FRAME_WORDS 115200

// outstanding accumulator fetches plus queued writebacks
`define RTX_QUEUE_DEPTH 8

// requests in flight at the controller
`define TAG_QUEUE_DEPTH 64

`endif

// ==== design/traffic_pkg.sv ====
`default_nettype none

`include "traffic_settings.svh"

package traffic_pkg;

    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [`MEM_DATA_W-1:0] mem_data_t;

    // red 4:0, green 10:5, blue 15:11
    typedef logic [`PIXEL_W-1:0] pixel_t;

    // accumulator channel fields
    typedef logic [20:0] chan21_t;
    typedef logic [21:0] chan22_t;

    // one half of an accumulation word, 64 bits
    typedef struct packed {
        chan21_t blue;
        chan22_t green;
        chan21_t red;
    } accum_t;

    // a controller request minus its enable
    typedef struct packed {
        mem_addr_t addr;
        logic      write_enable;
        mem_data_t write_data;
    } mem_req_t;

    // owner of an in-flight request
    typedef enum logic [1:0] {TAG_SCAN, TAG_FETCH, TAG_WRITEBACK} req_tag_t;

    // service slot of the arbiter
    typedef enum logic [1:0] {ST_RESET, ST_INIT, ST_SCAN, ST_RTX} slot_t;

endpackage

`default_nettype wire

// ==== design/command_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module command_fifo #(
    parameter int width = 8,
    parameter int depth = 8
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       write,
    input  wire logic [width-1:0]           command_in,
    input  wire logic                       read,
    output logic      [width-1:0]           command_out,
    output logic                            full,
    output logic                            empty,
    output logic      [$clog2(depth+1)-1:0] count
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             do_write;
    logic             do_read;

    // writes into a full queue and reads from an empty one are ignored
    assign do_write = write && !full;
    assign do_read = read && !empty;

    assign full = (count == ($clog2(depth+1))'(depth));
    assign empty = (count == '0);

    // head entry is visible without a read cycle
    assign command_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= command_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave occupancy alone
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/scanout_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "traffic_settings.svh"

module scanout_reader #(
    parameter int frame_words = `FRAME_WORDS
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  almost_full,
    input  wire logic                  grant,
    input  wire logic                  done,
    input  wire traffic_pkg::mem_data_t resp_data,
    output logic                       req_valid,
    output traffic_pkg::mem_req_t      req,
    output traffic_pkg::mem_data_t     stream_data,
    output logic                       stream_last,
    output logic                       stream_valid
);

    import traffic_pkg::*;

    localparam mem_addr_t last_word = mem_addr_t'(frame_words - 1);

    // next display word to request
    mem_addr_t issue_addr;
    // display word the next completion belongs to
    mem_addr_t return_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_addr <= '0;
            return_addr <= '0;
        end else begin
            if (grant) begin
                issue_addr <= (issue_addr == last_word) ? '0 : issue_addr + 1'b1;
            end
            if (done) begin
                return_addr <= (return_addr == last_word) ? '0 : return_addr + 1'b1;
            end
        end
    end

    // stop asking once the display FIFO runs short of room
    assign req_valid = !almost_full;
    assign req = '{addr: issue_addr, write_enable: 1'b0, write_data: '0};

    // completions arrive in issue order so the return counter names the word
    assign stream_data = resp_data;
    assign stream_valid = done;
    assign stream_last = (return_addr == last_word);

endmodule

`default_nettype wire

// ==== design/rtx_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "traffic_settings.svh"

module rtx_accumulator (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire traffic_pkg::pixel_t    sample,
    input  wire traffic_pkg::mem_addr_t pixel_addr,
    input  wire logic                   sample_last,
    input  wire logic                   sample_valid,
    input  wire logic                   fetch_grant,
    input  wire logic                   wb_grant,
    input  wire logic                   done,
    input  wire traffic_pkg::mem_data_t resp_data,
    output logic                        sample_ready,
    output logic                        fetch_valid,
    output traffic_pkg::mem_req_t       fetch_req,
    output logic                        wb_valid,
    output traffic_pkg::mem_req_t       wb_req
);

    import traffic_pkg::*;

    localparam int count_w = $clog2(`RTX_QUEUE_DEPTH + 1);

    // what a fetch needs to remember until its data returns
    typedef struct packed {
        mem_addr_t pixel_addr;
        pixel_t    sample;
        logic      overwrite;
    } pending_t;

    pending_t              new_entry;
    pending_t              head;
    logic    [count_w-1:0] pending_count;
    logic    [count_w-1:0] wb_count;
    logic                  wb_empty;
    accum_t                old_half;
    accum_t                new_half;
    chan21_t               s_red;
    chan22_t               s_green;
    chan21_t               s_blue;
    mem_data_t             rebuilt;
    mem_req_t              wb_entry;

    // two pixels share one word, the pixel index drops its low bit
    function automatic mem_addr_t word_addr(input mem_addr_t p);
        return `RTX_BASE | (p >> 1);
    endfunction

    // fetch and writeback share one budget so a writeback always has room
    assign fetch_valid = sample_valid &&
                         ((pending_count + wb_count) < `RTX_QUEUE_DEPTH);
    // a sample is taken exactly on its fetch grant
    assign sample_ready = fetch_grant;

    assign fetch_req = '{addr: word_addr(pixel_addr), write_enable: 1'b0, write_data: '0};
    assign new_entry = '{pixel_addr: pixel_addr, sample: sample, overwrite: sample_last};

    command_fifo #(
        .width($bits(pending_t)),
        .depth(`RTX_QUEUE_DEPTH)
    ) pending_fetch_q (
        .clk(clk),
        .rst(rst),
        .write(fetch_grant),
        .command_in(new_entry),
        .read(done),
        .command_out(head),
        .full(),
        .empty(),
        .count(pending_count)
    );

    // odd pixel sits in the low half, even pixel in the high half
    assign old_half = head.pixel_addr[0] ? accum_t'(resp_data[63:0])
                                         : accum_t'(resp_data[127:64]);

    // sample channels widened to the field sizes
    assign s_red = chan21_t'(head.sample[4:0]);
    assign s_green = chan22_t'(head.sample[10:5]);
    assign s_blue = chan21_t'(head.sample[15:11]);

    always_comb begin
        if (head.overwrite) begin
            // tlast restarts the accumulation from this sample
            new_half = '{blue: s_blue, green: s_green, red: s_red};
        end else begin
            // sums wrap at the field width
            new_half.blue = old_half.blue + s_blue;
            new_half.green = old_half.green + s_green;
            new_half.red = old_half.red + s_red;
        end
    end

    // untouched half goes back as it was read
    assign rebuilt = head.pixel_addr[0] ? {resp_data[127:64], new_half}
                                        : {new_half, resp_data[63:0]};

    assign wb_entry = '{addr: word_addr(head.pixel_addr), write_enable: 1'b1,
                        write_data: rebuilt};

    command_fifo #(
        .width($bits(mem_req_t)),
        .depth(`RTX_QUEUE_DEPTH)
    ) writeback_q (
        .clk(clk),
        .rst(rst),
        .write(done),
        .command_in(wb_entry),
        .read(wb_grant),
        .command_out(wb_req),
        .full(),
        .empty(wb_empty),
        .count(wb_count)
    );

    assign wb_valid = !wb_empty;

endmodule

`default_nettype wire

// ==== design/slot_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "traffic_settings.svh"

module slot_arbiter (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   scan_valid,
    input  wire traffic_pkg::mem_req_t  scan_req,
    input  wire logic                   fetch_valid,
    input  wire traffic_pkg::mem_req_t  fetch_req,
    input  wire logic                   wb_valid,
    input  wire traffic_pkg::mem_req_t  wb_req,
    input  wire logic                   memrequest_busy,
    input  wire logic                   memrequest_complete,
    output traffic_pkg::mem_addr_t      memrequest_addr,
    output logic                        memrequest_en,
    output logic                        memrequest_write_enable,
    output traffic_pkg::mem_data_t      memrequest_write_data,
    output logic                        scan_grant,
    output logic                        fetch_grant,
    output logic                        wb_grant,
    output logic                        scan_done,
    output logic                        rtx_done
);

    import traffic_pkg::*;

    localparam int tag_w = $bits(req_tag_t);

    slot_t              slot;
    logic               can_issue;
    logic               tag_full;
    logic               tag_empty;
    logic   [tag_w-1:0] head_bits;
    req_tag_t           head_tag;
    req_tag_t           issue_tag;
    mem_req_t           issue_req;

    // one cycle each through reset and init, then scan and rtx take turns
    always_ff @(posedge clk) begin
        if (rst) begin
            slot <= ST_RESET;
        end else begin
            case (slot)
                ST_RESET: slot <= ST_INIT;
                ST_INIT:  slot <= ST_SCAN;
                ST_SCAN:  slot <= ST_RTX;
                ST_RTX:   slot <= ST_SCAN;
                default:  slot <= ST_RESET;
            endcase
        end
    end

    // controller must be free and the tag queue must have a slot left
    assign can_issue = !memrequest_busy && !tag_full;

    assign scan_grant = (slot == ST_SCAN) && scan_valid && can_issue;
    // pending writebacks go before new fetches
    assign wb_grant = (slot == ST_RTX) && wb_valid && can_issue;
    assign fetch_grant = (slot == ST_RTX) && !wb_valid && fetch_valid && can_issue;

    always_comb begin
        issue_req = '0;
        issue_tag = TAG_SCAN;
        if (scan_grant) begin
            issue_req = scan_req;
            issue_tag = TAG_SCAN;
        end else if (wb_grant) begin
            issue_req = wb_req;
            issue_tag = TAG_WRITEBACK;
        end else if (fetch_grant) begin
            issue_req = fetch_req;
            issue_tag = TAG_FETCH;
        end
    end

    assign memrequest_en = scan_grant || wb_grant || fetch_grant;
    assign memrequest_addr = issue_req.addr;
    assign memrequest_write_enable = issue_req.write_enable;
    assign memrequest_write_data = issue_req.write_data;

    // owners of in-flight requests, oldest at the head
    command_fifo #(
        .width(tag_w),
        .depth(`TAG_QUEUE_DEPTH)
    ) tag_q (
        .clk(clk),
        .rst(rst),
        .write(memrequest_en),
        .command_in(issue_tag),
        .read(memrequest_complete),
        .command_out(head_bits),
        .full(tag_full),
        .empty(tag_empty),
        .count()
    );

    assign head_tag = req_tag_t'(head_bits);

    // writeback completions have no owner to notify
    assign scan_done = memrequest_complete && !tag_empty && (head_tag == TAG_SCAN);
    assign rtx_done = memrequest_complete && !tag_empty && (head_tag == TAG_FETCH);

endmodule

`default_nettype wire

// ==== design/traffic_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "traffic_settings.svh"

module traffic_generator #(
    parameter int frame_words = `FRAME_WORDS
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    // controller request port
    output traffic_pkg::mem_addr_t      memrequest_addr,
    output logic                        memrequest_en,
    output traffic_pkg::mem_data_t      memrequest_write_data,
    output logic                        memrequest_write_enable,
    input  wire traffic_pkg::mem_data_t memrequest_resp_data,
    input  wire logic                   memrequest_complete,
    input  wire logic                   memrequest_busy,
    // ray tracer samples
    input  wire traffic_pkg::pixel_t    write_axis_data,
    input  wire traffic_pkg::mem_addr_t write_axis_addr,
    input  wire logic                   write_axis_tlast,
    input  wire logic                   write_axis_valid,
    output logic                        write_axis_ready,
    // display words, throttled by af only
    output traffic_pkg::mem_data_t      read_axis_data,
    output logic                        read_axis_tlast,
    output logic                        read_axis_valid,
    input  wire logic                   read_axis_af,
    input  wire logic                   read_axis_ready
);

    import traffic_pkg::*;

    logic     scan_valid;
    mem_req_t scan_req;
    logic     scan_grant;
    logic     scan_done;
    logic     fetch_valid;
    mem_req_t fetch_req;
    logic     fetch_grant;
    logic     wb_valid;
    mem_req_t wb_req;
    logic     wb_grant;
    logic     rtx_done;

    scanout_reader #(.frame_words(frame_words)) scanout_i (
        .clk(clk), .rst(rst), .almost_full(read_axis_af), .grant(scan_grant),
        .done(scan_done), .resp_data(memrequest_resp_data), .req_valid(scan_valid),
        .req(scan_req), .stream_data(read_axis_data), .stream_last(read_axis_tlast),
        .stream_valid(read_axis_valid)
    );

    rtx_accumulator rtx_i (
        .clk(clk), .rst(rst), .sample(write_axis_data), .pixel_addr(write_axis_addr),
        .sample_last(write_axis_tlast), .sample_valid(write_axis_valid),
        .fetch_grant(fetch_grant), .wb_grant(wb_grant), .done(rtx_done),
        .resp_data(memrequest_resp_data), .sample_ready(write_axis_ready),
        .fetch_valid(fetch_valid), .fetch_req(fetch_req), .wb_valid(wb_valid), .wb_req(wb_req)
    );

    slot_arbiter arbiter_i (
        .clk(clk), .rst(rst), .scan_valid(scan_valid), .scan_req(scan_req),
        .fetch_valid(fetch_valid), .fetch_req(fetch_req), .wb_valid(wb_valid),
        .wb_req(wb_req), .memrequest_busy(memrequest_busy),
        .memrequest_complete(memrequest_complete), .memrequest_addr(memrequest_addr),
        .memrequest_en(memrequest_en), .memrequest_write_enable(memrequest_write_enable),
        .memrequest_write_data(memrequest_write_data), .scan_grant(scan_grant),
        .fetch_grant(fetch_grant), .wb_grant(wb_grant), .scan_done(scan_done),
        .rtx_done(rtx_done)
    );

endmodule

`default_nettype wire

// ==== verif/tb_traffic_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "traffic_settings.svh"

module tb_traffic_generator;

    import traffic_pkg::*;

    localparam int latency = 6;
    localparam int rows = 8;

    // one sample with its preloaded and expected half, channels as plain numbers
    typedef struct packed {
        mem_addr_t   px;
        logic        last;
        logic [4:0]  s_r;
        logic [5:0]  s_g;
        logic [4:0]  s_b;
        logic [21:0] p_r, p_g, p_b;
        logic [21:0] e_r, e_g, e_b;
    } sample_row_t;

    // read data waiting in the controller pipeline
    typedef struct packed {
        logic [31:0] due;
        mem_data_t   data;
    } completion_t;

    logic      clk = 1'b0;
    logic      rst;
    mem_addr_t memrequest_addr;
    logic      memrequest_en;
    mem_data_t memrequest_write_data;
    logic      memrequest_write_enable;
    mem_data_t memrequest_resp_data;
    logic      memrequest_complete;
    logic      memrequest_busy;
    pixel_t    write_axis_data;
    mem_addr_t write_axis_addr;
    logic      write_axis_tlast;
    logic      write_axis_valid;
    logic      write_axis_ready;
    mem_data_t read_axis_data;
    logic      read_axis_tlast;
    logic      read_axis_valid;
    logic      read_axis_af;
    logic      read_axis_ready;

    sample_row_t table_rows [rows];
    mem_data_t   mem_model [mem_addr_t];
    completion_t pending_q [$];
    logic [31:0] cycle = 0;
    logic [31:0] rnd = 32'had14_3897;
    int          rst_edges = 0;
    int          after_rst = 0;
    int          writes_seen = 0;
    int          scan_words = 0;
    int          scan_addr = 0;

    traffic_generator #(.frame_words(16)) dut_i (
        .clk(clk), .rst(rst), .memrequest_addr(memrequest_addr),
        .memrequest_en(memrequest_en), .memrequest_write_data(memrequest_write_data),
        .memrequest_write_enable(memrequest_write_enable),
        .memrequest_resp_data(memrequest_resp_data), .memrequest_complete(memrequest_complete),
        .memrequest_busy(memrequest_busy), .write_axis_data(write_axis_data),
        .write_axis_addr(write_axis_addr), .write_axis_tlast(write_axis_tlast),
        .write_axis_valid(write_axis_valid), .write_axis_ready(write_axis_ready),
        .read_axis_data(read_axis_data), .read_axis_tlast(read_axis_tlast),
        .read_axis_valid(read_axis_valid), .read_axis_af(read_axis_af),
        .read_axis_ready(read_axis_ready)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // contents of a never written word, every address bit shows up
    function automatic mem_data_t fill_word(input mem_addr_t a);
        return {8'ha5, a, 8'h3c, ~a, 8'h5a, a ^ 24'h6b_1d47, 8'hc3, a + 24'h11};
    endfunction

    function automatic mem_data_t read_word(input mem_addr_t a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return fill_word(a);
    endfunction

    // two pixels per accumulation word
    function automatic mem_addr_t word_of(input mem_addr_t px);
        return `RTX_BASE | (px >> 1);
    endfunction

    // blue on top, then green, red at the bottom
    function automatic logic [63:0] pack_half(input logic [21:0] r, input logic [21:0] g,
                                              input logic [21:0] b);
        return {b[20:0], g, r[20:0]};
    endfunction

    // odd pixel owns bits 63:0, even pixel bits 127:64
    function automatic mem_data_t place_half(input mem_addr_t px, input logic [63:0] half,
                                             input mem_data_t base);
        return px[0] ? {base[127:64], half} : {half, base[63:0]};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [127:0] expected,
                                 input logic [127:0] got);
        if (got !== expected) begin
            abort_run($sformatf("Error %s expected %0h got %0h", name, expected, got));
        end
    endtask

    task automatic check_quiet();
        compare_value("memrequest_en", 0, memrequest_en);
        compare_value("memrequest_write_enable", 0, memrequest_write_enable);
        compare_value("write_axis_ready", 0, write_axis_ready);
        compare_value("read_axis_valid", 0, read_axis_valid);
    endtask

    // controller model and stream monitor, sampled on the rising edge
    always @(posedge clk) begin : model
        completion_t entry;
        cycle = cycle + 1;
        // first edge of reset only clears the DUT, outputs are still unknown before it
        if (rst) begin
            if (rst_edges > 0) begin
                check_quiet();
            end
            rst_edges = rst_edges + 1;
            after_rst = 0;
        end else begin
            if (after_rst < 2) begin
                check_quiet();
            end
            after_rst = after_rst + 1;
        end
        if (memrequest_en && memrequest_busy) begin
            abort_run("a request was issued while the controller was busy");
        end
        if (memrequest_en && !memrequest_busy) begin
            if (memrequest_write_enable) begin
                mem_model[memrequest_addr] = memrequest_write_data;
                writes_seen = writes_seen + 1;
                entry.data = '0;
            end else begin
                if (read_axis_af && memrequest_addr < `RTX_BASE) begin
                    abort_run("a display read was issued while read_axis_af was high");
                end
                entry.data = read_word(memrequest_addr);
            end
            entry.due = cycle + latency;
            pending_q.push_back(entry);
        end
        // display words come back in address order and wrap after word 15
        if (read_axis_valid) begin
            compare_value("read_axis_data", fill_word(mem_addr_t'(scan_addr)), read_axis_data);
            compare_value("read_axis_tlast", scan_addr == 15, read_axis_tlast);
            scan_addr = (scan_addr == 15) ? 0 : scan_addr + 1;
            scan_words = scan_words + 1;
        end
        #1;
        rnd = xorshift(rnd);
        memrequest_busy = !rst && (rnd[2:0] < 3'd2);
        read_axis_af = (cycle % 48) >= 30;
        if (pending_q.size() > 0 && pending_q[0].due <= cycle) begin
            entry = pending_q.pop_front();
            memrequest_complete = 1'b1;
            memrequest_resp_data = entry.data;
        end else begin
            memrequest_complete = 1'b0;
            memrequest_resp_data = '0;
        end
    end

    initial begin
        int        t;
        logic      accepted;
        mem_addr_t waddr;
        // pixel, last, sample r g b, preload r g b, expected r g b
        table_rows[0] = '{24'h10, 1'b0, 5'd5, 6'd10, 5'd7,
                          22'd100, 22'd200, 22'd300, 22'd105, 22'd210, 22'd307};
        table_rows[1] = '{24'h23, 1'b0, 5'd31, 6'd63, 5'd31,
                          22'd1000, 22'd2000, 22'd3000, 22'd1031, 22'd2063, 22'd3031};
        table_rows[2] = '{24'h44, 1'b1, 5'd3, 6'd4, 5'd5,
                          22'd777, 22'd888, 22'd999, 22'd3, 22'd4, 22'd5};
        table_rows[3] = '{24'h65, 1'b1, 5'd17, 6'd33, 5'd9,
                          22'h1234, 22'h5678, 22'h9abc, 22'd17, 22'd33, 22'd9};
        // every channel wraps past its field width
        table_rows[4] = '{24'h86, 1'b0, 5'd3, 6'd1, 5'd2,
                          22'h1f_fffe, 22'h3f_ffff, 22'h1f_ffff, 22'd1, 22'd0, 22'd1};
        table_rows[5] = '{24'ha7, 1'b0, 5'd0, 6'd0, 5'd0,
                          22'd42, 22'd43, 22'd44, 22'd42, 22'd43, 22'd44};
        table_rows[6] = '{24'hc8, 1'b1, 5'd0, 6'd0, 5'd0,
                          22'd500, 22'd600, 22'd700, 22'd0, 22'd0, 22'd0};
        table_rows[7] = '{24'he9, 1'b0, 5'd16, 6'd32, 5'd16,
                          22'h10_0000, 22'h20_0000, 22'h10_0000,
                          22'h10_0010, 22'h20_0020, 22'h10_0010};
        for (int i = 0; i < rows; i++) begin
            waddr = word_of(table_rows[i].px);
            mem_model[waddr] = place_half(table_rows[i].px,
                pack_half(table_rows[i].p_r, table_rows[i].p_g, table_rows[i].p_b),
                fill_word(waddr));
        end
        rst = 1'b1;
        memrequest_busy = 1'b0;
        memrequest_complete = 1'b0;
        memrequest_resp_data = '0;
        read_axis_af = 1'b0;
        read_axis_ready = 1'b1;
        // first sample already waits during reset, ready has to stay low
        write_axis_data = {table_rows[0].s_b, table_rows[0].s_g, table_rows[0].s_r};
        write_axis_addr = table_rows[0].px;
        write_axis_tlast = table_rows[0].last;
        write_axis_valid = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < rows; i++) begin
            write_axis_data = {table_rows[i].s_b, table_rows[i].s_g, table_rows[i].s_r};
            write_axis_addr = table_rows[i].px;
            write_axis_tlast = table_rows[i].last;
            write_axis_valid = 1'b1;
            accepted = 1'b0;
            for (t = 0; t < 500 && !accepted; t++) begin
                @(posedge clk);
                accepted = write_axis_ready;
            end
            #1;
            if (!accepted) begin
                abort_run($sformatf("sample %0d was never accepted on the write stream", i));
            end
        end
        write_axis_valid = 1'b0;
        for (t = 0; t < 2000 && writes_seen < rows; t++) begin
            @(posedge clk);
            #1;
        end
        if (writes_seen < rows) begin
            abort_run("not every sample was written back to memory in time");
        end
        // at least two full passes over the display buffer
        for (t = 0; t < 2000 && scan_words < 40; t++) begin
            @(posedge clk);
            #1;
        end
        if (scan_words < 40) begin
            abort_run("the display stream stopped delivering words");
        end
        compare_value("writeback count", rows, writes_seen);
        for (int i = 0; i < rows; i++) begin
            waddr = word_of(table_rows[i].px);
            compare_value("accumulation word", place_half(table_rows[i].px,
                pack_half(table_rows[i].e_r, table_rows[i].e_g, table_rows[i].e_b),
                fill_word(waddr)), read_word(waddr));
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/traffic_pkg.sv
design/command_fifo.sv
design/scanout_reader.sv
design/rtx_accumulator.sv
design/slot_arbiter.sv
design/traffic_generator.sv
verif/tb_traffic_generator.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it, a $fatal gives a failing exit status
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_traffic_generator \
    -f filelist.f -o tb_sim &&
./obj_dir/tb_sim || exit 1
